/* source/id_pkg.sv */
package id_pkg;

    // Instruction word layout
    localparam int instr_w     = 24;
    localparam int opc_w       = 8;
    localparam int opclass_w   = 4;
    localparam int opc_lsb     = 16;
    localparam int opclass_lsb = 20;

    typedef logic [instr_w-1:0]   instr_t;
    typedef logic [opc_w-1:0]     opc_t;
    typedef logic [opclass_w-1:0] opclass_t;

    // Immediate sizes
    typedef logic [9:0]  imm10_t;
    typedef logic [11:0] imm12_t;
    typedef logic [13:0] imm14_t;
    typedef logic [15:0] imm16_t;

    typedef logic [3:0] cc_t;
    typedef logic [3:0] gp_idx_t;
    typedef logic [1:0] sr_idx_t;

    // Fixed special registers
    localparam sr_idx_t sr_idx_lr = 2'd1;
    localparam sr_idx_t sr_idx_fl = 2'd2;

    // Opcode classes
    localparam opclass_t opclass_ur   = 4'h0;
    localparam opclass_t opclass_ui   = 4'h1;
    localparam opclass_t opclass_sr   = 4'h2;
    localparam opclass_t opclass_si   = 4'h3;
    localparam opclass_t opclass_br   = 4'h5;
    localparam opclass_t opclass_mcc  = 4'h6;
    localparam opclass_t opclass_srop = 4'hF;

    // Unsigned register ALU
    localparam opc_t opc_mov_ur = 8'h00;
    localparam opc_t opc_add_ur = 8'h01;
    localparam opc_t opc_sub_ur = 8'h02;
    localparam opc_t opc_not_ur = 8'h03;
    localparam opc_t opc_and_ur = 8'h04;
    localparam opc_t opc_or_ur  = 8'h05;
    localparam opc_t opc_xor_ur = 8'h06;
    localparam opc_t opc_shl_ur = 8'h07;
    localparam opc_t opc_shr_ur = 8'h08;
    localparam opc_t opc_cmp_ur = 8'h09;
    localparam opc_t opc_tst_ur = 8'h0A;
    localparam opc_t opc_rol_ur = 8'h0B;
    localparam opc_t opc_ror_ur = 8'h0C;

    // Unsigned immediate ALU
    localparam opc_t opc_mov_ui = 8'h10;
    localparam opc_t opc_add_ui = 8'h11;
    localparam opc_t opc_sub_ui = 8'h12;
    localparam opc_t opc_and_ui = 8'h13;
    localparam opc_t opc_or_ui  = 8'h14;
    localparam opc_t opc_xor_ui = 8'h15;
    localparam opc_t opc_shl_ui = 8'h16;
    localparam opc_t opc_shr_ui = 8'h17;
    localparam opc_t opc_cmp_ui = 8'h18;
    localparam opc_t opc_rol_ui = 8'h19;
    localparam opc_t opc_ror_ui = 8'h1A;
    localparam opc_t opc_lui_ui = 8'h1B;

    // Signed register and immediate ALU
    localparam opc_t opc_add_sr = 8'h20;
    localparam opc_t opc_sub_sr = 8'h21;
    localparam opc_t opc_shr_sr = 8'h22;
    localparam opc_t opc_cmp_sr = 8'h23;
    localparam opc_t opc_neg_sr = 8'h24;
    localparam opc_t opc_tst_sr = 8'h25;
    localparam opc_t opc_mov_si = 8'h30;
    localparam opc_t opc_add_si = 8'h31;
    localparam opc_t opc_sub_si = 8'h32;
    localparam opc_t opc_shr_si = 8'h33;
    localparam opc_t opc_cmp_si = 8'h34;

    // Branches and conditional moves
    localparam opc_t opc_jcc_ui = 8'h50;
    localparam opc_t opc_bcc_sr = 8'h51;
    localparam opc_t opc_bcc_so = 8'h52;
    localparam opc_t opc_bal_so = 8'h53;
    localparam opc_t opc_mcc_ur = 8'h60;
    localparam opc_t opc_mcc_si = 8'h61;

    // Special register operations
    localparam opc_t opc_srmov_ur = 8'hF0;
    localparam opc_t opc_sradd_si = 8'hF1;
    localparam opc_t opc_srsub_si = 8'hF2;
    localparam opc_t opc_srjcc_so = 8'hF3;
    localparam opc_t opc_srst_so  = 8'hF4;
    localparam opc_t opc_srld_so  = 8'hF5;
    localparam opc_t opc_syscall  = 8'hF6;
    localparam opc_t opc_kret     = 8'hF7;

    typedef struct packed {
        logic sgn_en;
        logic imm_en;
        logic is_branch;
        logic uses_flags;
        logic has_src_gp;
        logic has_tgt_gp;
        logic tgt_gp_we;
        logic has_src_sr;
        logic has_tgt_sr;
        logic tgt_sr_we;
    } id_flags_t;

    typedef struct packed {
        imm12_t  imm12;
        imm14_t  imm14;
        imm10_t  imm10;
        imm16_t  imm16;
        cc_t     cc;
        gp_idx_t src_gp;
        gp_idx_t tgt_gp;
        sr_idx_t src_sr;
        sr_idx_t tgt_sr;
    } id_fields_t;

endpackage

/* source/id_class_decode.sv */
`timescale 1ns/1ps

module id_class_decode (
    input  id_pkg::instr_t    instr,
    output id_pkg::id_flags_t flags
);
    import id_pkg::*;

    opc_t     opc;
    opclass_t opclass;
    logic     defined;
    logic     alu_op;
    logic     cmp_tst_op;
    logic     mcc_op;
    logic     is_branch;
    logic     uses_flags;
    logic     tgt_gp_we;
    logic     tgt_sr_we;

    assign opc     = instr[opc_lsb +: opc_w];
    assign opclass = instr[opclass_lsb +: opclass_w];

    // Every class is packed from sub-op 0 up to its last opcode
    always_comb begin
        case (opclass)
            opclass_ur:   defined = (opc <= opc_ror_ur);
            opclass_ui:   defined = (opc <= opc_lui_ui);
            opclass_sr:   defined = (opc <= opc_tst_sr);
            opclass_si:   defined = (opc <= opc_cmp_si);
            opclass_br:   defined = (opc <= opc_bal_so);
            opclass_mcc:  defined = (opc <= opc_mcc_si);
            opclass_srop: defined = (opc <= opc_kret);
            default:      defined = 1'b0;
        endcase
    end

    // Classes 0 to 3 hold the plain ALU operations
    assign alu_op = defined &&
                    (opclass inside {opclass_ur, opclass_ui, opclass_sr, opclass_si});

    // Compares and tests set flags only
    assign cmp_tst_op = opc inside {opc_cmp_ur, opc_tst_ur, opc_cmp_ui,
                                    opc_cmp_sr, opc_tst_sr, opc_cmp_si};

    assign mcc_op = defined && (opclass == opclass_mcc);

    // Whole branch class plus the SR-relative jump
    assign is_branch  = (defined && (opclass == opclass_br)) || (opc == opc_srjcc_so);
    assign uses_flags = is_branch || mcc_op;

    // LUIui loads the upper part elsewhere, no GP write here
    assign tgt_gp_we = (alu_op && !cmp_tst_op && (opc != opc_lui_ui)) || mcc_op;

    // SYSCALL writes the return address into LR
    assign tgt_sr_we = opc inside {opc_srmov_ur, opc_sradd_si, opc_srsub_si,
                                   opc_srld_so, opc_syscall};

    always_comb begin
        flags.sgn_en = (defined && (opclass inside {opclass_sr, opclass_si})) ||
                       (opc inside {opc_bcc_sr, opc_bcc_so, opc_bal_so, opc_srjcc_so,
                                    opc_sradd_si, opc_srsub_si, opc_srst_so, opc_srld_so});

        flags.imm_en = (defined && (opclass inside {opclass_ui, opclass_si})) ||
                       (opc inside {opc_jcc_ui, opc_bcc_so, opc_bal_so, opc_srjcc_so,
                                    opc_sradd_si, opc_srsub_si, opc_srst_so, opc_srld_so,
                                    opc_syscall});

        flags.is_branch  = is_branch;
        flags.uses_flags = uses_flags;

        // NOT, NEG and TST take only the target register
        flags.has_src_gp = (defined && (opclass == opclass_ur) &&
                            !(opc inside {opc_not_ur, opc_tst_ur})) ||
                           (defined && (opclass == opclass_sr) &&
                            !(opc inside {opc_neg_sr, opc_tst_sr})) ||
                           (opc == opc_mcc_ur);

        // BCCsr reads its offset from the target field
        flags.has_tgt_gp = tgt_gp_we || cmp_tst_op || (opc == opc_bcc_sr);
        flags.tgt_gp_we  = tgt_gp_we;

        flags.has_src_sr = uses_flags ||
                           (opc inside {opc_srmov_ur, opc_srjcc_so, opc_srld_so, opc_srst_so});
        flags.has_tgt_sr = tgt_sr_we || (opc == opc_srst_so);
        flags.tgt_sr_we  = tgt_sr_we;
    end

endmodule

/* source/id_field_extract.sv */
`timescale 1ns/1ps

module id_field_extract (
    input  id_pkg::instr_t     instr,
    input  id_pkg::id_flags_t  flags,
    output id_pkg::id_fields_t fields
);
    import id_pkg::*;

    opc_t     opc;
    opclass_t opclass;
    logic     imm12_sel;

    assign opc     = instr[opc_lsb +: opc_w];
    assign opclass = instr[opclass_lsb +: opclass_w];

    // imm_en already excludes the undefined tail of both immediate classes
    assign imm12_sel = (flags.imm_en && (opclass inside {opclass_ui, opclass_si})) ||
                       (opc inside {opc_jcc_ui, opc_bcc_so, opc_srst_so, opc_srld_so,
                                    opc_syscall});

    always_comb begin
        fields = '0;

        // Immediates, one size per opcode
        if (imm12_sel) begin
            fields.imm12 = instr[11:0];
        end

        case (opc)
            opc_sradd_si,
            opc_srsub_si: begin
                fields.imm14 = instr[13:0];
            end
            opc_srjcc_so: begin
                fields.imm10 = instr[9:0];
            end
            opc_bal_so: begin
                // Long PC-relative offset for branch and link
                fields.imm16 = instr[15:0];
            end
            default: begin
            end
        endcase

        // Condition code position differs per format
        case (opc)
            opc_jcc_ui,
            opc_bcc_so: begin
                fields.cc = instr[15:12];
            end
            opc_bcc_sr,
            opc_mcc_si: begin
                fields.cc = instr[11:8];
            end
            opc_srjcc_so: begin
                fields.cc = instr[13:10];
            end
            opc_mcc_ur: begin
                fields.cc = instr[7:4];
            end
            default: begin
            end
        endcase

        // GP indices sit at fixed positions
        if (flags.has_tgt_gp) begin
            fields.tgt_gp = instr[15:12];
        end
        if (flags.has_src_gp) begin
            fields.src_gp = instr[11:8];
        end

        // KRET reads LR and SYSCALL writes it
        if ((opc == opc_kret) || (opc == opc_syscall)) begin
            fields.tgt_sr = sr_idx_lr;
        end else if (flags.has_tgt_sr) begin
            fields.tgt_sr = instr[15:14];
        end

        // Flag consumers read FL implicitly
        if (flags.uses_flags) begin
            fields.src_sr = sr_idx_fl;
        end else if (flags.has_src_sr) begin
            fields.src_sr = instr[13:12];
        end
    end

endmodule

/* source/id_pipe_reg.sv */
`timescale 1ns/1ps

module id_pipe_reg #(
    parameter int addr_w = 24
) (
    input  logic               iw_clk,
    input  logic               iw_rst,
    input  logic               flush,
    input  logic               stall,
    input  logic [addr_w-1:0]  pc,
    input  id_pkg::instr_t     instr,
    input  id_pkg::id_flags_t  flags,
    input  id_pkg::id_fields_t fields,
    output logic [addr_w-1:0]  pc_q,
    output id_pkg::opc_t       opc_q,
    output id_pkg::id_flags_t  flags_q,
    output id_pkg::id_fields_t fields_q
);
    import id_pkg::*;

    // Flush wins over stall, stall holds everything
    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            pc_q     <= '0;
            opc_q    <= '0;
            flags_q  <= '0;
            fields_q <= '0;
        end else if (flush) begin
            pc_q     <= '0;
            opc_q    <= '0;
            flags_q  <= '0;
            fields_q <= '0;
        end else if (!stall) begin
            pc_q     <= pc;
            opc_q    <= instr[opc_lsb +: opc_w];
            flags_q  <= flags;
            fields_q <= fields;
        end
    end

    // Decoder never sets a write enable without the matching target
    a_we_has_tgt: assert property (@(posedge iw_clk) disable iff (iw_rst)
        !(flags_q.tgt_gp_we && !flags_q.has_tgt_gp) &&
        !(flags_q.tgt_sr_we && !flags_q.has_tgt_sr))
        else $error("write enable without target register");

    a_flush_zero: assert property (@(posedge iw_clk) disable iff (iw_rst)
        flush |=> (pc_q == '0) && (opc_q == '0) && (flags_q == '0) && (fields_q == '0))
        else $error("outputs not cleared after flush");

    a_stall_hold: assert property (@(posedge iw_clk) disable iff (iw_rst)
        (stall && !flush) |=>
            $stable(pc_q) && $stable(opc_q) && $stable(flags_q) && $stable(fields_q))
        else $error("outputs changed during stall");

endmodule

/* source/id_stage.sv */
`timescale 1ns/1ps

module id_stage #(
    parameter int addr_w = 24
) (
    input  logic               iw_clk,
    input  logic               iw_rst,
    input  logic [addr_w-1:0]  pc,
    input  id_pkg::instr_t     instr,
    input  logic               flush,
    input  logic               stall,
    output logic [addr_w-1:0]  pc_q,
    output id_pkg::opc_t       opc_q,
    output id_pkg::id_flags_t  flags_q,
    output id_pkg::id_fields_t fields_q
);
    import id_pkg::*;

    // Combinational decode results
    id_flags_t  flags;
    id_fields_t fields;

    id_class_decode u_class_decode (
        .instr (instr),
        .flags (flags)
    );

    id_field_extract u_field_extract (
        .instr  (instr),
        .flags  (flags),
        .fields (fields)
    );

    id_pipe_reg #(
        .addr_w (addr_w)
    ) u_pipe_reg (
        .iw_clk   (iw_clk),
        .iw_rst   (iw_rst),
        .flush    (flush),
        .stall    (stall),
        .pc       (pc),
        .instr    (instr),
        .flags    (flags),
        .fields   (fields),
        .pc_q     (pc_q),
        .opc_q    (opc_q),
        .flags_q  (flags_q),
        .fields_q (fields_q)
    );

endmodule

/* verif/id_stage_ref.svh */
`ifndef ID_STAGE_REF_SVH
`define ID_STAGE_REF_SVH

// Expected decode of one instruction
typedef struct packed {
    id_flags_t  flags;
    id_fields_t fields;
} dec_t;

localparam int n_defined = 50;

localparam opc_t defined_list [n_defined] = '{
    opc_mov_ur, opc_add_ur, opc_sub_ur, opc_not_ur, opc_and_ur, opc_or_ur, opc_xor_ur,
    opc_shl_ur, opc_shr_ur, opc_cmp_ur, opc_tst_ur, opc_rol_ur, opc_ror_ur,
    opc_mov_ui, opc_add_ui, opc_sub_ui, opc_and_ui, opc_or_ui, opc_xor_ui,
    opc_shl_ui, opc_shr_ui, opc_cmp_ui, opc_rol_ui, opc_ror_ui, opc_lui_ui,
    opc_add_sr, opc_sub_sr, opc_shr_sr, opc_cmp_sr, opc_neg_sr, opc_tst_sr,
    opc_mov_si, opc_add_si, opc_sub_si, opc_shr_si, opc_cmp_si,
    opc_jcc_ui, opc_bcc_sr, opc_bcc_so, opc_bal_so, opc_mcc_ur, opc_mcc_si,
    opc_srmov_ur, opc_sradd_si, opc_srsub_si, opc_srjcc_so, opc_srst_so, opc_srld_so,
    opc_syscall, opc_kret
};

function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
endfunction

function automatic logic is_defined(input opc_t op);
    logic found;
    int   k;
    found = 1'b0;
    for (k = 0; k < n_defined; k++) begin
        if (defined_list[k] == op) begin
            found = 1'b1;
        end
    end
    return found;
endfunction

function automatic dec_t ref_decode(input instr_t ins);
    dec_t     d;
    opc_t     op;
    opclass_t cls;
    logic     cmp_tst;
    d   = '0;
    op  = ins[23:16];
    cls = ins[23:20];
    if (is_defined(op)) begin
        cmp_tst = op inside {opc_cmp_ur, opc_tst_ur, opc_cmp_ui, opc_cmp_sr, opc_tst_sr,
                             opc_cmp_si};
        d.flags.is_branch  = (cls == opclass_br) || (op == opc_srjcc_so);
        d.flags.uses_flags = d.flags.is_branch || (cls == opclass_mcc);
        d.flags.sgn_en     = (cls == opclass_sr) || (cls == opclass_si) ||
                             (op inside {opc_bcc_sr, opc_bcc_so, opc_bal_so, opc_srjcc_so,
                                         opc_sradd_si, opc_srsub_si, opc_srst_so, opc_srld_so});
        d.flags.imm_en     = (cls == opclass_ui) || (cls == opclass_si) ||
                             (op inside {opc_jcc_ui, opc_bcc_so, opc_bal_so, opc_srjcc_so,
                                         opc_sradd_si, opc_srsub_si, opc_srst_so, opc_srld_so,
                                         opc_syscall});
        d.flags.tgt_gp_we  = ((cls <= opclass_si) && !cmp_tst && (op != opc_lui_ui)) ||
                             (cls == opclass_mcc);
        d.flags.has_tgt_gp = d.flags.tgt_gp_we || cmp_tst || (op == opc_bcc_sr);
        d.flags.has_src_gp = ((cls == opclass_ur) && !(op inside {opc_not_ur, opc_tst_ur})) ||
                             ((cls == opclass_sr) && !(op inside {opc_neg_sr, opc_tst_sr})) ||
                             (op == opc_mcc_ur);
        d.flags.tgt_sr_we  = op inside {opc_srmov_ur, opc_sradd_si, opc_srsub_si, opc_srld_so,
                                        opc_syscall};
        d.flags.has_tgt_sr = d.flags.tgt_sr_we || (op == opc_srst_so);
        d.flags.has_src_sr = d.flags.uses_flags ||
                             (op inside {opc_srmov_ur, opc_srjcc_so, opc_srld_so, opc_srst_so});

        // Immediates
        if ((cls == opclass_ui) || (cls == opclass_si) ||
            (op inside {opc_jcc_ui, opc_bcc_so, opc_srst_so, opc_srld_so, opc_syscall})) begin
            d.fields.imm12 = ins[11:0];
        end
        if (op inside {opc_sradd_si, opc_srsub_si}) begin
            d.fields.imm14 = ins[13:0];
        end
        if (op == opc_srjcc_so) begin
            d.fields.imm10 = ins[9:0];
        end
        if (op == opc_bal_so) begin
            d.fields.imm16 = ins[15:0];
        end

        // Condition code
        if (op inside {opc_jcc_ui, opc_bcc_so}) begin
            d.fields.cc = ins[15:12];
        end else if (op inside {opc_bcc_sr, opc_mcc_si}) begin
            d.fields.cc = ins[11:8];
        end else if (op == opc_srjcc_so) begin
            d.fields.cc = ins[13:10];
        end else if (op == opc_mcc_ur) begin
            d.fields.cc = ins[7:4];
        end

        // Register indices
        if (d.flags.has_tgt_gp) begin
            d.fields.tgt_gp = ins[15:12];
        end
        if (d.flags.has_src_gp) begin
            d.fields.src_gp = ins[11:8];
        end
        if ((op == opc_kret) || (op == opc_syscall)) begin
            d.fields.tgt_sr = sr_idx_lr;
        end else if (d.flags.has_tgt_sr) begin
            d.fields.tgt_sr = ins[15:14];
        end
        if (d.flags.uses_flags) begin
            d.fields.src_sr = sr_idx_fl;
        end else if (d.flags.has_src_sr) begin
            d.fields.src_sr = ins[13:12];
        end
    end
    return d;
endfunction

task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
        report_failure($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
    end
endtask

task automatic check_flags(input string name, input id_flags_t got, input id_flags_t exp);
    if (got !== exp) begin
        report_failure($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
    end
endtask

task automatic check_fields(input string name, input id_fields_t got, input id_fields_t exp);
    if (got !== exp) begin
        report_failure($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
    end
endtask

`endif

/* verif/tb_id_stage.sv */
`timescale 1ns/1ps

module tb_id_stage;
    import id_pkg::*;

    localparam int addr_w = 24;

    `include "id_stage_ref.svh"

    logic              iw_clk;
    logic              iw_rst;
    logic [addr_w-1:0] pc;
    instr_t            instr;
    logic              flush;
    logic              stall;
    logic [addr_w-1:0] pc_q;
    opc_t              opc_q;
    id_flags_t         flags_q;
    id_fields_t        fields_q;

    // Expected outputs trail the inputs by one cycle
    logic [addr_w-1:0] exp_pc;
    opc_t              exp_opc;
    dec_t              exp_dec;
    logic [31:0]       lcg_state;

    id_stage #(
        .addr_w (addr_w)
    ) DUT (
        .iw_clk   (iw_clk),
        .iw_rst   (iw_rst),
        .pc       (pc),
        .instr    (instr),
        .flush    (flush),
        .stall    (stall),
        .pc_q     (pc_q),
        .opc_q    (opc_q),
        .flags_q  (flags_q),
        .fields_q (fields_q)
    );

    always #10 iw_clk = ~iw_clk;

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Regression failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic draw_random(output logic [31:0] r);
        lcg_state = lcg_next(lcg_state);
        r = lcg_state;
    endtask

    // Mostly defined opcodes with about one in eight undefined
    task automatic random_instr(output instr_t ins);
        logic [31:0] r;
        logic [31:0] s;
        opc_t        op;
        int          tries;
        draw_random(r);
        draw_random(s);
        if (r[31:29] == 3'd0) begin
            op    = s[31:24];
            tries = 0;
            while (is_defined(op) && (tries < 32)) begin
                draw_random(s);
                op = s[31:24];
                tries++;
            end
            if (is_defined(op)) begin
                op = 8'h4F;
            end
        end else begin
            op = defined_list[r[23:8] % n_defined];
        end
        ins = {op, s[23:8]};
    endtask

    task automatic drive_instr(input logic [addr_w-1:0] pc_v, input instr_t instr_v);
        @(posedge iw_clk);
        pc    <= pc_v;
        instr <= instr_v;
    endtask

    // Counts edges until pc_q shows the given pc
    task automatic wait_for_pc(input logic [addr_w-1:0] target, input int limit,
                               output int cycles);
        cycles = 0;
        while (pc_q !== target) begin
            if (cycles >= limit) begin
                report_failure("timeout waiting for pc_q to show the released instruction");
            end
            @(posedge iw_clk);
            cycles++;
            @(negedge iw_clk);
        end
    endtask

    task automatic expect_cleared();
        @(negedge iw_clk);
        check_word("pc_q", 32'(pc_q), 32'h0);
        check_word("opc_q", 32'(opc_q), 32'h0);
        check_flags("flags_q", flags_q, '0);
        check_fields("fields_q", fields_q, '0);
    endtask

    // Model of the output register
    always @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst || flush) begin
            exp_pc  <= '0;
            exp_opc <= '0;
            exp_dec <= '0;
        end else if (!stall) begin
            exp_pc  <= pc;
            exp_opc <= instr[23:16];
            exp_dec <= ref_decode(instr);
        end
    end

    always @(negedge iw_clk) begin
        check_word("pc_q", 32'(pc_q), 32'(exp_pc));
        check_word("opc_q", 32'(opc_q), 32'(exp_opc));
        check_flags("flags_q", flags_q, exp_dec.flags);
        check_fields("fields_q", fields_q, exp_dec.fields);
    end

    initial begin
        logic [31:0] r;
        instr_t      ins;
        int          i;
        int          cycles;
        iw_clk    = 1'b0;
        iw_rst    = 1'b1;
        pc        = '0;
        instr     = '0;
        flush     = 1'b0;
        stall     = 1'b0;
        lcg_state = 32'h69ea;
        repeat (10) @(posedge iw_clk);
        iw_rst <= 1'b0;

        for (i = 0; i < n_defined; i++) begin
            draw_random(r);
            drive_instr(r[31:8], {defined_list[i], r[15:0]});
        end

        // Sweep of all undefined opcodes
        for (i = 0; i < 256; i++) begin
            if (!is_defined(opc_t'(i))) begin
                draw_random(r);
                drive_instr(r[31:8], {opc_t'(i), r[15:0]});
            end
        end

        // Stall held for five cycles with changing inputs
        random_instr(ins);
        drive_instr(24'h000100, ins);
        @(posedge iw_clk);
        stall <= 1'b1;
        for (i = 0; i < 5; i++) begin
            random_instr(ins);
            drive_instr(24'h000200 + 24'(i), ins);
        end
        random_instr(ins);
        @(posedge iw_clk);
        stall <= 1'b0;
        pc    <= 24'hABCDE0;
        instr <= ins;
        wait_for_pc(24'hABCDE0, 8, cycles);
        if (cycles != 1) begin
            report_failure($sformatf("instruction after stall release took %0d cycles",
                                     cycles));
        end

        // Flush alone and then flush together with stall
        drive_instr(24'h000300, {opc_add_ur, 16'h5A5A});
        @(posedge iw_clk);
        flush <= 1'b1;
        @(posedge iw_clk);
        flush <= 1'b0;
        expect_cleared();
        drive_instr(24'h000400, {opc_bal_so, 16'hC3C3});
        @(posedge iw_clk);
        flush <= 1'b1;
        stall <= 1'b1;
        @(posedge iw_clk);
        flush <= 1'b0;
        stall <= 1'b0;
        expect_cleared();

        for (i = 0; i < 300; i++) begin
            random_instr(ins);
            draw_random(r);
            drive_instr(r[31:8], ins);
        end

        repeat (3) @(posedge iw_clk);
        $display("Regression passed");
        $finish;
    end

endmodule

/* id_stage.f */
+incdir+verif
source/id_pkg.sv
source/id_class_decode.sv
source/id_field_extract.sv
source/id_pipe_reg.sv
source/id_stage.sv
verif/tb_id_stage.sv

/* Bender.yml */
package:
  name: id_stage

sources:
  - source/id_pkg.sv
  - source/id_class_decode.sv
  - source/id_field_extract.sv
  - source/id_pipe_reg.sv
  - source/id_stage.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/tb_id_stage.sv
